// ==== bp_cfg.svh ====
// sizes assume RV32 with 4-byte aligned fetch; BTB entries must be a power of two >= 2, history >= 2
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// number of BTB entries
`define BP_BTB_ENTRIES 32

// global history length, also the PHT index width
`define BP_GHR_BITS 5

// RISC-V major opcodes for control transfer
`define BP_OP_BRANCH 7'b1100011
`define BP_OP_JAL    7'b1101111
`define BP_OP_JALR   7'b1100111

`endif

// ==== bp_pkg.sv ====
// types shared by fetch, execute and the predictor; field widths track bp_cfg.svh
`default_nettype none

`include "bp_cfg.svh"

package bp_pkg;

    // what the BTB remembers about a control instruction
    typedef enum logic [1:0] {
        kind_none   = 2'd0,
        kind_branch = 2'd1,
        kind_jump   = 2'd2
    } br_kind_t;

    // 2-bit saturating direction counter, upper bit means taken
    typedef logic [1:0] ctr_t;

    // prediction handed to fetch
    typedef struct packed {
        logic                      taken;
        logic [31:0]               target;
        logic [`BP_GHR_BITS-1:0]   pht_idx;
    } pred_t;

    // report from execute for one resolved instruction
    typedef struct packed {
        logic                      valid;
        logic [31:0]               pc;
        logic [6:0]                op;
        logic [31:0]               target;
        logic                      taken;
        // index the prediction was made with, carried down the pipe
        logic [`BP_GHR_BITS-1:0]   pht_idx;
    } resolve_t;

endpackage

`default_nettype wire

// ==== bp_btb.sv ====
// direct-mapped BTB with full-PC tags; a write shows up on lookups from the next cycle only
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module bp_btb (
    input  wire logic             clk,
    input  wire logic             rst_n_i,

    // lookup side
    input  wire logic [31:0]      pc_i,
    output logic                  hit_o,
    output bp_pkg::br_kind_t      kind_o,
    output logic [31:0]           target_o,

    // write side, from the resolve path
    input  wire logic             wr_en_i,
    input  wire logic [31:0]      wr_pc_i,
    input  wire bp_pkg::br_kind_t wr_kind_i,
    input  wire logic [31:0]      wr_target_i
);

    localparam int entries  = `BP_BTB_ENTRIES;
    localparam int idx_bits = $clog2(entries);

    // one table row
    typedef struct packed {
        logic [31:0]      tag;
        logic [31:0]      target;
        bp_pkg::br_kind_t kind;
    } entry_t;

    logic [entries-1:0]  valid_q;
    entry_t              mem_q [entries];

    logic [idx_bits-1:0] rd_idx;
    logic [idx_bits-1:0] wr_idx;
    entry_t              rd_entry;

    // word aligned, so the index starts above the byte offset
    assign rd_idx = pc_i[idx_bits+1:2];
    assign wr_idx = wr_pc_i[idx_bits+1:2];

    assign rd_entry = mem_q[rd_idx];

    // the whole PC is kept as tag, so aliasing never produces a false hit
    assign hit_o    = valid_q[rd_idx] && (rd_entry.tag == pc_i);
    assign kind_o   = rd_entry.kind;
    assign target_o = rd_entry.target;

    // only the valid bits need a known state after reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // a new resolve always replaces whatever sat in the slot
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_idx] <= '{
                tag:    wr_pc_i,
                target: wr_target_i,
                kind:   wr_kind_i
            };
        end
    end

endmodule

`default_nettype wire

// ==== bp_gshare.sv ====
// gshare direction predictor; history holds actual outcomes, counters start weakly not taken
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module bp_gshare (
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,

    // lookup side
    input  wire logic [31:0]             pc_i,
    output logic [`BP_GHR_BITS-1:0]      pht_idx_o,
    output logic                         predict_taken_o,

    // update side, branches only
    input  wire logic                    upd_en_i,
    input  wire logic [`BP_GHR_BITS-1:0] upd_idx_i,
    input  wire logic                    upd_taken_i
);

    localparam int hist_bits = `BP_GHR_BITS;
    localparam int pht_size  = 1 << hist_bits;

    logic [hist_bits-1:0] ghr_q;
    bp_pkg::ctr_t         pht_q [pht_size];

    logic [hist_bits-1:0] rd_idx;
    bp_pkg::ctr_t         rd_ctr;
    bp_pkg::ctr_t         upd_ctr;
    bp_pkg::ctr_t         upd_ctr_next;

    // pc bits above the byte offset hashed with the history
    assign rd_idx = pc_i[hist_bits+1:2] ^ ghr_q;
    assign rd_ctr = pht_q[rd_idx];

    assign pht_idx_o       = rd_idx;
    assign predict_taken_o = rd_ctr[1];

    // saturating step toward the outcome
    assign upd_ctr = pht_q[upd_idx_i];

    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd_taken_i && (upd_ctr != 2'b11)) begin
            upd_ctr_next = upd_ctr + 2'd1;
        end else if (!upd_taken_i && (upd_ctr != 2'b00)) begin
            upd_ctr_next = upd_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < pht_size; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (upd_en_i) begin
            pht_q[upd_idx_i] <= upd_ctr_next;
        end
    end

    // newest outcome enters at bit 0
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (upd_en_i) begin
            ghr_q <= {ghr_q[hist_bits-2:0], upd_taken_i};
        end
    end

endmodule

`default_nettype wire

// ==== bp_predictor.sv ====
// fetch-stage branch predictor; prediction is combinational on pc_i, one resolve per cycle, no stall
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module bp_predictor (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    input  wire logic [31:0]      pc_i,
    input  wire bp_pkg::resolve_t res_i,
    output bp_pkg::pred_t         pred_o
);

    bp_pkg::br_kind_t         res_kind;
    logic                     btb_wr_en;
    logic                     pht_upd_en;

    logic                     btb_hit;
    bp_pkg::br_kind_t         btb_kind;
    logic [31:0]              btb_target;
    logic [`BP_GHR_BITS-1:0]  pht_idx;
    logic                     ctr_taken;

    // the resolved opcode is decoded here once for both tables
    always_comb begin
        case (res_i.op)
            `BP_OP_BRANCH: res_kind = bp_pkg::kind_branch;
            `BP_OP_JAL,
            `BP_OP_JALR:   res_kind = bp_pkg::kind_jump;
            default:       res_kind = bp_pkg::kind_none;
        endcase
    end

    assign btb_wr_en  = res_i.valid && (res_kind != bp_pkg::kind_none);
    // jumps leave direction state alone
    assign pht_upd_en = res_i.valid && (res_kind == bp_pkg::kind_branch);

    bp_btb u_btb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pc_i        (pc_i),
        .hit_o       (btb_hit),
        .kind_o      (btb_kind),
        .target_o    (btb_target),
        .wr_en_i     (btb_wr_en),
        .wr_pc_i     (res_i.pc),
        .wr_kind_i   (res_kind),
        .wr_target_i (res_i.target)
    );

    bp_gshare u_gshare (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pc_i            (pc_i),
        .pht_idx_o       (pht_idx),
        .predict_taken_o (ctr_taken),
        .upd_en_i        (pht_upd_en),
        .upd_idx_i       (res_i.pht_idx),
        .upd_taken_i     (res_i.taken)
    );

    // a miss never predicts taken, whatever the counter says
    always_comb begin
        pred_o.taken   = btb_hit && ((btb_kind == bp_pkg::kind_jump) ||
                                     ((btb_kind == bp_pkg::kind_branch) && ctr_taken));
        pred_o.target  = btb_hit ? btb_target : 32'd0;
        pred_o.pht_idx = pht_idx;
    end

endmodule

`default_nettype wire

// ==== bp_assertions.sv ====
// checks on the predictor output; sampled on rising clk, all but the reset check idle during reset
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module bp_assertions (
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire logic [31:0]             pc_i,
    input  wire logic                    jump_wr_i,
    input  wire logic [31:0]             wr_pc_i,
    input  wire logic                    pred_taken_i,
    input  wire logic [`BP_GHR_BITS-1:0] pht_idx_i,
    input  wire logic                    btb_hit_i
);

    // a jump resolved at one edge hits and predicts taken on the next lookup of its PC
    jump_seen_next: assert property (@(posedge clk) disable iff (!rst_n_i)
        jump_wr_i |=> ((pc_i != $past(wr_pc_i)) || (btb_hit_i && pred_taken_i)))
        else $error("a jump resolved in the previous cycle was not predicted taken");

    idx_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(pht_idx_i))
        else $error("pht_idx has unknown bits");

    // all tables are cold right after reset
    cold_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !pred_taken_i)
        else $error("taken predicted in the first cycle after reset");

endmodule

bind bp_predictor bp_assertions u_assertions (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .pc_i         (pc_i),
    .jump_wr_i    (res_i.valid && (res_kind == bp_pkg::kind_jump)),
    .wr_pc_i      (res_i.pc),
    .pred_taken_i (pred_o.taken),
    .pht_idx_i    (pred_o.pht_idx),
    .btb_hit_i    (btb_hit)
);

`default_nettype wire

// ==== bp_tb.sv ====
// directed testbench for bp_predictor; expects 32 BTB entries or more and 4-byte aligned PCs
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module bp_tb;

    localparam int btb_bits   = $clog2(`BP_BTB_ENTRIES);
    localparam int hist_bits  = `BP_GHR_BITS;
    localparam int max_cycles = 500;
    localparam logic [6:0] op_alu = 7'b0010011;

    logic             clk;
    logic             rst_n_i;
    logic [31:0]      pc_i;
    bp_pkg::resolve_t res_i;
    bp_pkg::pred_t    pred_o;

    // reference model state
    logic                 m_valid [`BP_BTB_ENTRIES];
    logic [31:0]          m_tag [`BP_BTB_ENTRIES];
    logic [31:0]          m_target [`BP_BTB_ENTRIES];
    logic                 m_jump [`BP_BTB_ENTRIES];
    bp_pkg::ctr_t         m_pht [1 << hist_bits];
    logic [hist_bits-1:0] m_ghr;

    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    integer seed   = 32'h17bee701;

    bp_predictor UUT (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .pc_i    (pc_i),
        .res_i   (res_i),
        .pred_o  (pred_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [hist_bits-1:0] model_idx(input logic [31:0] pc);
        return pc[hist_bits+1:2] ^ m_ghr;
    endfunction

    function automatic bp_pkg::pred_t model_pred(input logic [31:0] pc);
        bp_pkg::pred_t p;
        int            bi;
        bi = pc[btb_bits+1:2];
        p.pht_idx = model_idx(pc);
        p.taken   = 1'b0;
        p.target  = 32'd0;
        if (m_valid[bi] && (m_tag[bi] == pc)) begin
            p.target = m_target[bi];
            p.taken  = m_jump[bi] || m_pht[p.pht_idx][1];
        end
        return p;
    endfunction

    function automatic bp_pkg::resolve_t make_res(input logic valid, input logic [31:0] pc,
                                                  input logic [6:0] op, input logic [31:0] target,
                                                  input logic taken,
                                                  input logic [hist_bits-1:0] idx);
        bp_pkg::resolve_t r;
        r.valid   = valid;
        r.pc      = pc;
        r.op      = op;
        r.target  = target;
        r.taken   = taken;
        r.pht_idx = idx;
        return r;
    endfunction

    // applies one resolve by the rules for BTB, counters and history
    task automatic model_update(input bp_pkg::resolve_t r);
        int  bi;
        logic is_br;
        bi    = r.pc[btb_bits+1:2];
        is_br = (r.op == `BP_OP_BRANCH);
        if (r.valid && (is_br || r.op == `BP_OP_JAL || r.op == `BP_OP_JALR)) begin
            m_valid[bi]  = 1'b1;
            m_tag[bi]    = r.pc;
            m_target[bi] = r.target;
            m_jump[bi]   = !is_br;
        end
        if (r.valid && is_br) begin
            if (r.taken && m_pht[r.pht_idx] != 2'd3) begin
                m_pht[r.pht_idx] = m_pht[r.pht_idx] + 2'd1;
            end else if (!r.taken && m_pht[r.pht_idx] != 2'd0) begin
                m_pht[r.pht_idx] = m_pht[r.pht_idx] - 2'd1;
            end
            m_ghr = {m_ghr[hist_bits-2:0], r.taken};
        end
    endtask

    // entered just after a falling edge and left at the next one
    task automatic drive_cycle(input string name, input logic [31:0] pc,
                               input bp_pkg::resolve_t r);
        bp_pkg::pred_t exp;
        pc_i  = pc;
        res_i = r;
        #1;
        exp = model_pred(pc);
        checks++;
        assert (pred_o === exp) else begin
            $write("ERROR %s: pc %h expected taken=%0b target=%h idx=%0d",
                   name, pc, exp.taken, exp.target, exp.pht_idx);
            $display(", actual taken=%0b target=%h idx=%0d",
                     pred_o.taken, pred_o.target, pred_o.pht_idx);
            errors++;
        end
        @(posedge clk);
        model_update(r);
        @(negedge clk);
    endtask

    task automatic cold_state();
        logic [31:0] pcs [4] = '{32'h0000_0100, 32'h8000_0044, 32'h1234_5678, 32'hffff_fffc};
        foreach (pcs[i]) begin
            drive_cycle("cold_state", pcs[i], '0);
            // history is still zero here and the index is the plain pc slice
            checks++;
            assert (pred_o.pht_idx === pcs[i][hist_bits+1:2]) else begin
                $display("ERROR cold_state: pc %h expected idx=%0d actual idx=%0d",
                         pcs[i], pcs[i][hist_bits+1:2], pred_o.pht_idx);
                errors++;
            end
        end
    endtask

    task automatic jump_learning();
        drive_cycle("jump_learning", 32'h0000_1000,
                    make_res(1'b1, 32'h0000_1000, `BP_OP_JAL, 32'h0000_2000, 1'b1, '0));
        drive_cycle("jump_learning", 32'h0000_1000,
                    make_res(1'b1, 32'h0000_1044, `BP_OP_JALR, 32'h0000_3abc, 1'b1, '0));
        drive_cycle("jump_learning", 32'h0000_1044, '0);
        drive_cycle("jump_learning", 32'h0000_1000, '0);
    endtask

    task automatic tag_check();
        // same index as 32'h0000_1000 but different upper bits
        drive_cycle("tag_check", 32'h0001_1000,
                    make_res(1'b1, 32'h0001_1000, `BP_OP_JAL, 32'h0000_4000, 1'b1, '0));
        drive_cycle("tag_check", 32'h0001_1000, '0);
        drive_cycle("tag_check", 32'h0000_1000, '0);
    endtask

    task automatic counter_saturation();
        logic [31:0]          pc;
        logic [hist_bits-1:0] fixed_idx;
        pc        = 32'h0000_0208;
        fixed_idx = pc[hist_bits+1:2];
        repeat (3) begin
            drive_cycle("counter_saturation", pc,
                        make_res(1'b1, pc, `BP_OP_BRANCH, 32'h0000_0100, 1'b1, model_idx(pc)));
        end
        drive_cycle("counter_saturation", pc, '0);
        // hammer one counter while the zeros also clear the history
        repeat (hist_bits) begin
            drive_cycle("counter_saturation", pc,
                        make_res(1'b1, pc, `BP_OP_BRANCH, 32'h0000_0100, 1'b0, fixed_idx));
        end
        drive_cycle("counter_saturation", pc,
                    make_res(1'b1, pc, `BP_OP_BRANCH, 32'h0000_0100, 1'b1, fixed_idx));
        drive_cycle("counter_saturation", pc, '0);
    endtask

    // counter 3 is the one read for 0x208 here and sits at 2, so a stray decrement shows
    task automatic non_control();
        drive_cycle("non_control", 32'h0001_1000,
                    make_res(1'b1, 32'h0001_1000, op_alu, 32'h0000_9000, 1'b0, 5'd3));
        drive_cycle("non_control", 32'h0000_0208,
                    make_res(1'b1, 32'h0000_0208, op_alu, 32'h0000_9000, 1'b0, 5'd3));
        drive_cycle("non_control", 32'h0001_1000, '0);
        drive_cycle("non_control", 32'h0000_0208, '0);
    endtask

    task automatic random_stream();
        logic [31:0] pcs [8] = '{32'h0000_1000, 32'h0000_1044, 32'h0001_1000, 32'h0000_0208,
                                 32'h0000_0300, 32'h0000_0304, 32'h8000_0008, 32'h0000_0088};
        logic [6:0]  ops [4] = '{`BP_OP_BRANCH, `BP_OP_JAL, `BP_OP_JALR, op_alu};
        logic [31:0] r;
        logic [31:0] t;
        logic [31:0] rpc;
        repeat (200) begin
            r   = $random(seed);
            t   = $random(seed);
            rpc = pcs[r[9:7]];
            drive_cycle("random_stream", pcs[r[2:0]],
                        make_res(r[5], rpc, ops[r[4:3]], {t[31:2], 2'b00}, r[6],
                                 model_idx(rpc)));
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        pc_i    = 32'd0;
        res_i   = '0;
        m_ghr   = '0;
        foreach (m_valid[i]) begin
            m_valid[i] = 1'b0;
        end
        foreach (m_pht[i]) begin
            m_pht[i] = 2'd1;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        cold_state();
        jump_learning();
        tag_check();
        counter_saturation();
        non_control();
        random_stream();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
bp_pkg.sv
bp_btb.sv
bp_gshare.sv
bp_predictor.sv
bp_assertions.sv
bp_tb.sv

// ==== Bender.yml ====
package:
  name: bp_predictor

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - bp_pkg.sv
      - bp_btb.sv
      - bp_gshare.sv
      - bp_predictor.sv
      - target: test
        files:
          - bp_assertions.sv
          - bp_tb.sv
